//--- include/aidc_defines.svh
`ifndef AIDC_DEFINES_SVH
`define AIDC_DEFINES_SVH

// ---------------------------------------------------------
// word, code and block geometry
// ---------------------------------------------------------
`define AIDC_WORD_W     64
`define AIDC_CODE_W     66
`define AIDC_SIZE_W     7
`define AIDC_BLK_WORDS  8
`define AIDC_ADDR_W     3
`define AIDC_BLK_BITS   512

// marker in front of every packed block
`define AIDC_PREFIX     2'b01

// code tags, top two bits of each code
`define AIDC_TAG_ZERO   2'b00
`define AIDC_TAG_S8     2'b01
`define AIDC_TAG_S32    2'b10
`define AIDC_TAG_RAW    2'b11

// block is sent raw above this many bits
`define AIDC_FAIL_BITS  `AIDC_BLK_BITS

`endif

//--- hw/aidc_code_pkg.sv
`include "aidc_defines.svh"

package aidc_code_pkg;

    // one host word, block strobes qualified by valid
    typedef struct packed {
        logic                       valid;
        logic                       sop;
        logic                       eop;
        logic [`AIDC_WORD_W-1:0]    word;
    } in_beat_t;

    // tagged code, left-aligned, size in bits
    typedef struct packed {
        logic                       valid;
        logic                       sop;
        logic                       eop;
        logic [`AIDC_CODE_W-1:0]    code;
        logic [`AIDC_SIZE_W-1:0]    size;
    } code_t;

endpackage

//--- hw/aidc_blk_pkg.sv
`include "aidc_defines.svh"

package aidc_blk_pkg;

    // one packed word and its place in the block
    typedef struct packed {
        logic                       valid;
        logic [`AIDC_ADDR_W-1:0]    addr;
        logic [`AIDC_WORD_W-1:0]    word;
    } pack_wr_t;

    // done is a level, fail valid while done is high
    typedef struct packed {
        logic                       done;
        logic                       fail;
    } blk_stat_t;

    // output beat, comp set when the word is packed data
    typedef struct packed {
        logic                       valid;
        logic [`AIDC_ADDR_W-1:0]    idx;
        logic                       comp;
        logic [`AIDC_WORD_W-1:0]    word;
    } out_beat_t;

endpackage

//--- hw/aidc_code_encoder.sv
`timescale 1ns/1ps
`include "aidc_defines.svh"

module aidc_code_encoder
    import aidc_code_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  in_beat_t    beat_i,
    output code_t       code_o
);

    logic                       is_zero;
    logic                       is_s8;
    logic                       is_s32;
    logic [`AIDC_CODE_W-1:0]    code_d;
    logic [`AIDC_SIZE_W-1:0]    size_d;

    logic                       vld_q;
    logic                       sop_q;
    logic                       eop_q;
    logic [`AIDC_CODE_W-1:0]    code_q;
    logic [`AIDC_SIZE_W-1:0]    size_q;

    // ---------------------------------------------------------
    // classify, first matching tag wins
    // ---------------------------------------------------------
    always_comb begin
        is_zero = (beat_i.word == '0);
        is_s8   = (beat_i.word[`AIDC_WORD_W-1:8] == {(`AIDC_WORD_W-8){beat_i.word[7]}});
        is_s32  = (beat_i.word[`AIDC_WORD_W-1:32] == {(`AIDC_WORD_W-32){beat_i.word[31]}});

        if (is_zero) begin
            code_d = {`AIDC_TAG_ZERO, {`AIDC_WORD_W{1'b0}}};
            size_d = `AIDC_SIZE_W'(2);
        end else if (is_s8) begin
            // low byte only, rest of the code stays zero
            code_d = {`AIDC_TAG_S8, beat_i.word[7:0], {(`AIDC_WORD_W-8){1'b0}}};
            size_d = `AIDC_SIZE_W'(10);
        end else if (is_s32) begin
            code_d = {`AIDC_TAG_S32, beat_i.word[31:0], {(`AIDC_WORD_W-32){1'b0}}};
            size_d = `AIDC_SIZE_W'(34);
        end else begin
            code_d = {`AIDC_TAG_RAW, beat_i.word};
            size_d = `AIDC_SIZE_W'(66);
        end
    end

    // ---------------------------------------------------------
    // output register
    // ---------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= beat_i.valid;
        end
    end

    // payload only moves with a valid beat
    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            sop_q  <= beat_i.sop;
            eop_q  <= beat_i.eop;
            code_q <= code_d;
            size_q <= size_d;
        end
    end

    assign code_o = '{
        valid: vld_q,
        sop:   sop_q,
        eop:   eop_q,
        code:  code_q,
        size:  size_q
    };

endmodule

//--- hw/aidc_code_concatenate.sv
`timescale 1ns/1ps
`include "aidc_defines.svh"

module aidc_code_concatenate
    import aidc_code_pkg::*, aidc_blk_pkg::*;
#(
    parameter logic [1:0] PREFIX = `AIDC_PREFIX
) (
    input  logic        clk,
    input  logic        rst_n,
    input  code_t       code_i,
    output pack_wr_t    wr_o,
    output blk_stat_t   stat_o
);

    // backlog after an eop code can reach one full code
    localparam int CARRY_W   = `AIDC_CODE_W;
    localparam int TMP_W     = CARRY_W + `AIDC_CODE_W;
    localparam int BLK_WORDS = `AIDC_BLK_WORDS;

    logic [CARRY_W-1:0]         carry_q, carry_n;
    logic [6:0]                 buf_q,   buf_n;
    logic [9:0]                 blk_q,   blk_n;
    logic [3:0]                 cnt_q,   cnt_n;
    logic                       flush_q, flush_n;
    logic                       done_q,  done_n;
    logic                       fail_q,  fail_n;

    logic                       wr_vld_q,  wr_vld_n;
    logic [3:0]                 wr_addr_q, wr_addr_n;
    logic [`AIDC_WORD_W-1:0]    wr_word_q, wr_word_n;
    logic                       word_drop;

    // ---------------------------------------------------------
    // merge code into carry and emit at most one word
    // ---------------------------------------------------------
    always_comb begin
        logic [TMP_W-1:0]   tmp;
        logic [7:0]         sum;
        logic               last;

        tmp    = {carry_q, {`AIDC_CODE_W{1'b0}}};
        sum    = {1'b0, buf_q};
        last   = flush_q;
        blk_n  = blk_q;
        done_n = done_q;
        fail_n = fail_q;

        if (code_i.valid) begin
            // new code lands right behind the held bits
            tmp   = tmp | ({code_i.code, {CARRY_W{1'b0}}} >> buf_q);
            sum   = sum + {1'b0, code_i.size};
            blk_n = blk_q + 10'(code_i.size);
            last  = code_i.eop;
            if (code_i.sop) begin
                done_n = 1'b0;
                fail_n = 1'b0;
            end
            if (code_i.eop) begin
                done_n = 1'b1;
                fail_n = (blk_n > `AIDC_FAIL_BITS);
            end
        end

        // full word or the zero-padded tail at block end
        wr_vld_n  = 1'b0;
        wr_addr_n = cnt_q;
        wr_word_n = tmp[TMP_W-1 -: `AIDC_WORD_W];
        cnt_n     = cnt_q;
        word_drop = 1'b0;
        if (sum >= 8'd64 || last) begin
            // words past the eighth are dropped
            wr_vld_n  = (cnt_q < 4'(BLK_WORDS));
            word_drop = !wr_vld_n;
            if (wr_vld_n) begin
                cnt_n = cnt_q + 4'd1;
            end
        end

        if (sum >= 8'd64) begin
            carry_n = tmp[TMP_W-`AIDC_WORD_W-1 -: CARRY_W];
            buf_n   = 7'(sum - 8'd64);
        end else begin
            carry_n = tmp[TMP_W-1 -: CARRY_W];
            buf_n   = sum[6:0];
        end

        // a tail longer than one word drains on the next cycle
        flush_n = 1'b0;
        if (last && sum <= 8'd64) begin
            carry_n = {PREFIX, {(CARRY_W-2){1'b0}}};
            buf_n   = 7'd2;
            blk_n   = 10'd2;
            cnt_n   = 4'd0;
        end else if (last) begin
            flush_n = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry_q  <= {PREFIX, {(CARRY_W-2){1'b0}}};
            buf_q    <= 7'd2;
            blk_q    <= 10'd2;
            cnt_q    <= 4'd0;
            flush_q  <= 1'b0;
            done_q   <= 1'b1;
            fail_q   <= 1'b0;
            wr_vld_q <= 1'b0;
        end else begin
            carry_q  <= carry_n;
            buf_q    <= buf_n;
            blk_q    <= blk_n;
            cnt_q    <= cnt_n;
            flush_q  <= flush_n;
            done_q   <= done_n;
            fail_q   <= fail_n;
            wr_vld_q <= wr_vld_n;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q <= wr_addr_n;
        wr_word_q <= wr_word_n;
    end

    assign wr_o   = '{valid: wr_vld_q, addr: wr_addr_q[`AIDC_ADDR_W-1:0], word: wr_word_q};
    assign stat_o = '{done: done_q, fail: fail_q};

    // ---------------------------------------------------------
    // checks
    // ---------------------------------------------------------
    // a word past address 7 is only ever due in a block that fails
    a_addr_in_block: assert property (@(posedge clk) disable iff (!rst_n)
        word_drop |-> fail_n)
        else $error("word past address %0d in a block that fits", BLK_WORDS - 1);

    // encoder never hands over an empty code
    a_code_size: assert property (@(posedge clk) disable iff (!rst_n)
        code_i.valid |-> (code_i.size != '0))
        else $error("valid code with zero size");

endmodule

//--- hw/aidc_block_buffer.sv
`timescale 1ns/1ps
`include "aidc_defines.svh"

module aidc_block_buffer
    import aidc_code_pkg::*, aidc_blk_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  in_beat_t    beat_i,
    input  pack_wr_t    wr_i,
    input  blk_stat_t   stat_i,
    output out_beat_t   out_o,
    output logic        busy_o
);

    logic [`AIDC_WORD_W-1:0]    raw_mem  [`AIDC_BLK_WORDS];
    logic [`AIDC_WORD_W-1:0]    pack_mem [`AIDC_BLK_WORDS];
    logic [`AIDC_BLK_WORDS-1:0] pack_set_q;

    logic [`AIDC_ADDR_W-1:0]    raw_idx_q;
    logic [`AIDC_ADDR_W-1:0]    raw_idx;
    logic [`AIDC_ADDR_W-1:0]    emit_idx_q;
    logic                       done_q;
    logic                       busy_q;
    logic                       rise;
    logic                       fire;
    logic [`AIDC_WORD_W-1:0]    pack_word;
    logic [`AIDC_WORD_W-1:0]    emit_word;

    logic                       out_vld_q;
    logic [`AIDC_ADDR_W-1:0]    out_idx_q;
    logic                       out_comp_q;
    logic [`AIDC_WORD_W-1:0]    out_word_q;

    // ---------------------------------------------------------
    // storage
    // ---------------------------------------------------------
    assign raw_idx = beat_i.sop ? '0 : raw_idx_q;

    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            raw_mem[raw_idx] <= beat_i.word;
        end
        if (wr_i.valid) begin
            pack_mem[wr_i.addr] <= wr_i.word;
        end
    end

    // ---------------------------------------------------------
    // emission
    // ---------------------------------------------------------
    assign rise = stat_i.done & ~done_q;
    assign fire = rise | (busy_q & (emit_idx_q != '0));

    always_comb begin
        // the tail word can arrive in the same cycle it is read
        if (wr_i.valid && wr_i.addr == emit_idx_q) begin
            pack_word = wr_i.word;
        end else if (pack_set_q[emit_idx_q]) begin
            pack_word = pack_mem[emit_idx_q];
        end else begin
            pack_word = '0;
        end
        emit_word = stat_i.fail ? raw_mem[emit_idx_q] : pack_word;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raw_idx_q  <= '0;
            pack_set_q <= '0;
            emit_idx_q <= '0;
            done_q     <= 1'b1;
            busy_q     <= 1'b0;
            out_vld_q  <= 1'b0;
        end else begin
            if (beat_i.valid) begin
                raw_idx_q <= raw_idx + 1'b1;
            end
            if (beat_i.valid && beat_i.sop) begin
                pack_set_q <= '0;
            end
            if (wr_i.valid) begin
                pack_set_q[wr_i.addr] <= 1'b1;
            end
            if (fire) begin
                emit_idx_q <= emit_idx_q + 1'b1;
            end
            done_q    <= stat_i.done;
            busy_q    <= fire;
            out_vld_q <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_idx_q  <= emit_idx_q;
            out_comp_q <= ~stat_i.fail;
            out_word_q <= emit_word;
        end
    end

    assign out_o  = '{valid: out_vld_q, idx: out_idx_q, comp: out_comp_q, word: out_word_q};
    assign busy_o = busy_q;

    // host must hold off while a block drains
    a_no_beat_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o |-> !beat_i.valid)
        else $error("input beat while busy");

    a_eight_beats: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(stat_i.done) |=> out_vld_q [*8] ##1 !out_vld_q)
        else $error("done rise not followed by exactly eight beats");

endmodule

//--- hw/aidc_compressor_top.sv
`timescale 1ns/1ps

module aidc_compressor_top
    import aidc_code_pkg::*, aidc_blk_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  in_beat_t    in_i,
    output out_beat_t   out_o,
    output logic        busy_o
);

    code_t      code;
    pack_wr_t   pack_wr;
    blk_stat_t  blk_stat;

    // word to tagged code
    aidc_code_encoder u_encoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .beat_i (in_i),
        .code_o (code)
    );

    // codes to addressed 64-bit words
    aidc_code_concatenate u_concat (
        .clk    (clk),
        .rst_n  (rst_n),
        .code_i (code),
        .wr_o   (pack_wr),
        .stat_o (blk_stat)
    );

    aidc_block_buffer u_buffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .beat_i (in_i),
        .wr_i   (pack_wr),
        .stat_i (blk_stat),
        .out_o  (out_o),
        .busy_o (busy_o)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

//--- bench/tb_aidc_compressor.sv
`timescale 1ns/1ps
`include "aidc_defines.svh"

module tb_aidc_compressor
    import aidc_code_pkg::*, aidc_blk_pkg::*;
();

    localparam int DRIVE_DLY = 2;
    localparam int BUSY_WAIT = 20;

    logic           clk;
    logic           rst_n;
    in_beat_t       in_beat;
    out_beat_t      out_beat;
    logic           busy;

    integer         seed = 32'ha38b;
    int             err_value = 0;
    int             err_other = 0;
    logic           timed_out = 1'b0;
    string          test_name = "reset state";
    logic [511:0]   exp_blk = '0;
    logic           exp_comp = 1'b0;
    logic           expect_out = 1'b0;
    int             beat_cnt = 0;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    aidc_compressor_top UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_i   (in_beat),
        .out_o  (out_beat),
        .busy_o (busy)
    );

    // ------------------------------------------------------------
    // reference model returning {compressed flag, eight words}
    // ------------------------------------------------------------
    function automatic logic [512:0] ref_block(input logic [511:0] raw);
        logic [1023:0]  stream;
        logic [65:0]    code;
        logic [63:0]    w;
        int             size;
        int             pos;

        stream = '0;
        stream[1023 -: 2] = `AIDC_PREFIX;
        pos = 2;
        for (int i = 0; i < 8; i++) begin
            w = raw[511 - 64*i -: 64];
            // smallest signed range that holds the word
            if (w == 64'd0) begin
                code = {64'd0, `AIDC_TAG_ZERO};
                size = 2;
            end else if ($signed(w) >= -128 && $signed(w) <= 127) begin
                code = {56'd0, `AIDC_TAG_S8, w[7:0]};
                size = 10;
            end else if ($signed(w) >= -64'sd2147483648 && $signed(w) <= 64'sd2147483647) begin
                code = {32'd0, `AIDC_TAG_S32, w[31:0]};
                size = 34;
            end else begin
                code = {`AIDC_TAG_RAW, w};
                size = 66;
            end
            for (int b = size - 1; b >= 0; b--) begin
                stream[1023 - pos] = code[b];
                pos++;
            end
        end
        if (pos > `AIDC_BLK_BITS) begin
            return {1'b0, raw};
        end else begin
            return {1'b1, stream[1023 -: 512]};
        end
    endfunction

    // kind 0 zero, 1 byte range, 2 word range, 3 full width
    function automatic logic [63:0] make_word(input int kind, input logic [31:0] lo,
                                              input logic [31:0] hi);
        case (kind)
            0:       return 64'd0;
            1:       return {{56{lo[7]}}, lo[7:0]};
            2:       return {{32{lo[31]}}, lo[31], ~lo[31], lo[29:0]};
            default: return {2'b01, hi[29:0], lo};
        endcase
    endfunction

    task automatic shape_block(input int mode, output logic [511:0] raw);
        int             kind;
        int             slot;
        logic [31:0]    lo;
        logic [31:0]    hi;

        slot = $unsigned($random(seed)) % 8;
        for (int i = 0; i < 8; i++) begin
            lo = $random(seed);
            hi = $random(seed);
            case (mode)
                0:       kind = 0;
                1:       kind = (i % 2 == 0) ? 1 : 2;
                2:       kind = 3;
                3:       kind = (i == slot) ? 2 : 3;
                default: kind = $unsigned($random(seed)) % 4;
            endcase
            raw[511 - 64*i -: 64] = make_word(kind, lo, hi);
        end
    endtask

    // ------------------------------------------------------------
    // run control
    // ------------------------------------------------------------
    task automatic end_run;
        $display("error counts: %0d value, %0d other", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic wait_reset;
        int n;

        n = 0;
        while (rst_n !== 1'b1 && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            err_other++;
            timed_out = 1'b1;
            $display("reset was never released");
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;

        n = 0;
        while (busy !== level && n < BUSY_WAIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy !== level) begin
            err_other++;
            timed_out = 1'b1;
            $display("%s: timed out waiting for busy_o to go to %0d", test_name, level);
        end
    endtask

    task automatic send_block(input logic [511:0] raw);
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            in_beat.valid = 1'b1;
            in_beat.sop   = (i == 0);
            in_beat.eop   = (i == 7);
            in_beat.word  = raw[511 - 64*i -: 64];
        end
        @(posedge clk);
        #DRIVE_DLY;
        in_beat = '0;
    endtask

    task automatic run_block(input string name, input int mode);
        logic [511:0] raw;

        if (timed_out) begin
            return;
        end
        shape_block(mode, raw);
        test_name = name;
        {exp_comp, exp_blk} = ref_block(raw);
        beat_cnt = 0;
        expect_out = 1'b1;
        send_block(raw);
        wait_busy(1'b1);
        if (!timed_out) begin
            wait_busy(1'b0);
        end
        expect_out = 1'b0;
        if (!timed_out) begin
            assert (beat_cnt == 8) else begin
                err_value++;
                $display("ERROR %s beat count: expected 8, actual %0d", test_name, beat_cnt);
            end
        end
    endtask

    // ------------------------------------------------------------
    // compare on the falling edge where outputs are stable
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (out_beat.valid === 1'b1) begin
            assert (expect_out && beat_cnt <= 7) else begin
                err_other++;
                $display("%s: output beat arrived with no block pending", test_name);
            end
            if (expect_out && beat_cnt <= 7) begin
                assert (out_beat.idx == beat_cnt[2:0]) else begin
                    err_value++;
                    $display("ERROR %s index: expected %0d, actual %0d",
                             test_name, beat_cnt, out_beat.idx);
                end
                assert (out_beat.word == exp_blk[511 - 64*beat_cnt -: 64]) else begin
                    err_value++;
                    $display("ERROR %s word %0d: expected %h, actual %h", test_name,
                             beat_cnt, exp_blk[511 - 64*beat_cnt -: 64], out_beat.word);
                end
                assert (out_beat.comp == exp_comp) else begin
                    err_value++;
                    $display("ERROR %s flag %0d: expected %0d, actual %0d",
                             test_name, beat_cnt, exp_comp, out_beat.comp);
                end
                beat_cnt++;
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        in_beat = '0;
        wait_reset();

        // idle after reset while the comparing process flags any beat
        if (!timed_out) begin
            for (int i = 0; i < 6; i++) begin
                @(posedge clk);
                #1;
                assert (busy === 1'b0) else begin
                    err_value++;
                    $display("ERROR %s busy_o: expected 0, actual %b", test_name, busy);
                end
            end
        end

        run_block("all zero", 0);
        run_block("mixed small", 1);
        // 2 + 8 * 66 = 530 bits
        run_block("all raw", 2);
        // all codes are 2 mod 8 long so 512 exactly cannot occur
        // 7 raw plus one word-range code give 498 bits, the largest block that fits
        run_block("fit limit", 3);
        for (int b = 0; b < 6; b++) begin
            run_block($sformatf("random %0d", b), 4);
        end

        repeat (3) @(posedge clk);
        end_run();
    end

endmodule

//--- flist.f
+incdir+include
hw/aidc_code_pkg.sv
hw/aidc_blk_pkg.sv
hw/aidc_code_encoder.sv
hw/aidc_code_concatenate.sv
hw/aidc_block_buffer.sv
hw/aidc_compressor_top.sv
bench/tb_clk_gen.sv
bench/tb_aidc_compressor.sv
